// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_bmu_decode
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx '>>> PASS' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== design/bmu_consts.svh ====
`ifndef BMU_CONSTS_SVH
`define BMU_CONSTS_SVH

// Datapath and bundle geometry.
`define XLEN            32
`define REG_ADDR_W      5
`define DECODE_LANES    2
`define LANE_IDX_W      1

// Major opcodes of the integer register and immediate groups.
`define OPC_OP          7'b0110011
`define OPC_OP_IMM      7'b0010011

// Funct7 values of the bit-manipulation encodings.
`define F7_LOGIC_N      7'b0100000
`define F7_ROTATE       7'b0110000
`define F7_MINMAX       7'b0000101
`define F7_SHADD        7'b0010000
`define F7_BSET         7'b0010100
`define F7_BCLR         7'b0100100
`define F7_BINV         7'b0110100
`define F7_BEXT         7'b0100100

// Whole imm12 field of the byte operations.
`define IMM12_REV8      12'b011010011000
`define IMM12_ORCB      12'b001010000111

`endif

// ==== design/bmu_decode_lane.sv ====
`include "bmu_consts.svh"

module bmu_decode_lane (
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  logic                      load_i,
    input  riscv_isa_pkg::instr_t     instr_i,
    output bmu_uop_pkg::bmu_op_t      op_o,
    output riscv_isa_pkg::reg_addr_t  rs1_o,
    output riscv_isa_pkg::reg_addr_t  rs2_o,
    output riscv_isa_pkg::reg_addr_t  rd_o,
    output logic [`XLEN-1:0]          imm_o,
    output logic                      use_imm_o,
    output logic                      illegal_o
);

    bmu_uop_pkg::bmu_op_t     op_d;
    riscv_isa_pkg::reg_addr_t rs1_d;
    riscv_isa_pkg::reg_addr_t rs2_d;
    riscv_isa_pkg::reg_addr_t rd_d;
    logic [`XLEN-1:0]         imm_d;
    logic                     reg_form;
    logic                     shamt_form;
    logic                     illegal_d;

    // **************************************************
    // Combinational decode
    // **************************************************

    always_comb begin : decode
        op_d       = bmu_uop_pkg::BMU_NONE;
        reg_form   = 1'b0;
        shamt_form = 1'b0;

        // Major opcode is matched on bits 6:2 only.
        case ({instr_i.r.opcode[6:2], 2'b11})
            `OPC_OP: begin
                reg_form = 1'b1;
                case ({instr_i.r.funct7, instr_i.r.funct3})
                    {`F7_LOGIC_N, 3'b111}: op_d = bmu_uop_pkg::BMU_ANDN;
                    {`F7_LOGIC_N, 3'b110}: op_d = bmu_uop_pkg::BMU_ORN;
                    {`F7_LOGIC_N, 3'b100}: op_d = bmu_uop_pkg::BMU_XNOR;
                    {`F7_ROTATE,  3'b001}: op_d = bmu_uop_pkg::BMU_ROL;
                    {`F7_ROTATE,  3'b101}: op_d = bmu_uop_pkg::BMU_ROR;
                    {`F7_MINMAX,  3'b100}: op_d = bmu_uop_pkg::BMU_MIN;
                    {`F7_MINMAX,  3'b101}: op_d = bmu_uop_pkg::BMU_MINU;
                    {`F7_MINMAX,  3'b110}: op_d = bmu_uop_pkg::BMU_MAX;
                    {`F7_MINMAX,  3'b111}: op_d = bmu_uop_pkg::BMU_MAXU;
                    {`F7_SHADD,   3'b010}: op_d = bmu_uop_pkg::BMU_SH1ADD;
                    {`F7_SHADD,   3'b100}: op_d = bmu_uop_pkg::BMU_SH2ADD;
                    {`F7_SHADD,   3'b110}: op_d = bmu_uop_pkg::BMU_SH3ADD;
                    {`F7_BSET,    3'b001}: op_d = bmu_uop_pkg::BMU_BSET;
                    {`F7_BCLR,    3'b001}: op_d = bmu_uop_pkg::BMU_BCLR;
                    {`F7_BINV,    3'b001}: op_d = bmu_uop_pkg::BMU_BINV;
                    {`F7_BEXT,    3'b101}: op_d = bmu_uop_pkg::BMU_BEXT;
                    default:               reg_form = 1'b0;
                endcase
            end

            `OPC_OP_IMM: begin
                shamt_form = 1'b1;
                case ({instr_i.r.funct7, instr_i.r.funct3})
                    {`F7_BSET,   3'b001}: op_d = bmu_uop_pkg::BMU_BSETI;
                    {`F7_BCLR,   3'b001}: op_d = bmu_uop_pkg::BMU_BCLRI;
                    {`F7_BINV,   3'b001}: op_d = bmu_uop_pkg::BMU_BINVI;
                    {`F7_BEXT,   3'b101}: op_d = bmu_uop_pkg::BMU_BEXTI;
                    {`F7_ROTATE, 3'b101}: op_d = bmu_uop_pkg::BMU_RORI;
                    default: begin
                        shamt_form = 1'b0;
                        // Byte operations need the full immediate.
                        if ({instr_i.i.imm12, instr_i.i.funct3} == {`IMM12_REV8, 3'b101}) begin
                            op_d = bmu_uop_pkg::BMU_REV8;
                        end else if ({instr_i.i.imm12, instr_i.i.funct3} ==
                                     {`IMM12_ORCB, 3'b101}) begin
                            op_d = bmu_uop_pkg::BMU_ORCB;
                        end
                    end
                endcase
            end

            default: ;
        endcase

        rs1_d = (op_d != bmu_uop_pkg::BMU_NONE) ? instr_i.r.rs1 : '0;
        rd_d  = (op_d != bmu_uop_pkg::BMU_NONE) ? instr_i.r.rd : '0;
        rs2_d = reg_form ? instr_i.r.rs2 : '0;
        imm_d = shamt_form ? {{(`XLEN - `REG_ADDR_W){1'b0}}, instr_i.r.rs2} : '0;
    end : decode

    assign illegal_d = (instr_i.r.opcode[1:0] != 2'b11);  // Not a 32-bit encoding.

    // **************************************************
    // Micro-op register
    // **************************************************

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            op_o      <= bmu_uop_pkg::BMU_NONE;
            use_imm_o <= 1'b0;
            illegal_o <= 1'b0;
        end else if (load_i) begin
            op_o      <= op_d;
            use_imm_o <= shamt_form;
            illegal_o <= illegal_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load_i) begin
            rs1_o <= rs1_d;
            rs2_o <= rs2_d;
            rd_o  <= rd_d;
            imm_o <= imm_d;
        end
    end

    // Immediate operand only for the shift-amount forms.
    a_imm_only_shamt: assert property (@(posedge clk_i) disable iff (reset_i)
        use_imm_o |-> op_o inside {bmu_uop_pkg::BMU_BSETI, bmu_uop_pkg::BMU_BCLRI,
                                   bmu_uop_pkg::BMU_BINVI, bmu_uop_pkg::BMU_BEXTI,
                                   bmu_uop_pkg::BMU_RORI});

endmodule : bmu_decode_lane

// ==== design/bmu_decode_top.sv ====
`include "bmu_consts.svh"

module bmu_decode_top (
    input  logic                                       clk_i,
    input  logic                                       reset_i,
    input  logic                                       bundle_req_i,
    input  riscv_isa_pkg::instr_t [`DECODE_LANES-1:0]  bundle_i,
    output logic                                       bundle_ack_o,
    output logic                                       uop_req_o,
    input  logic                                       uop_ack_i,
    output bmu_uop_pkg::bmu_op_t                       uop_op_o,
    output riscv_isa_pkg::reg_addr_t                   uop_rs1_o,
    output riscv_isa_pkg::reg_addr_t                   uop_rs2_o,
    output riscv_isa_pkg::reg_addr_t                   uop_rd_o,
    output logic [`XLEN-1:0]                           uop_imm_o,
    output logic                                       uop_use_imm_o,
    output logic                                       uop_illegal_o,
    output logic [`LANE_IDX_W-1:0]                     uop_lane_o
);

    logic                                          lane_load;
    logic                                          lanes_free;
    riscv_isa_pkg::instr_t [`DECODE_LANES-1:0]     lane_instr;
    bmu_uop_pkg::bmu_op_t [`DECODE_LANES-1:0]      lane_op;
    riscv_isa_pkg::reg_addr_t [`DECODE_LANES-1:0]  lane_rs1;
    riscv_isa_pkg::reg_addr_t [`DECODE_LANES-1:0]  lane_rs2;
    riscv_isa_pkg::reg_addr_t [`DECODE_LANES-1:0]  lane_rd;
    logic [`DECODE_LANES-1:0][`XLEN-1:0]           lane_imm;
    logic [`DECODE_LANES-1:0]                      lane_use_imm;
    logic [`DECODE_LANES-1:0]                      lane_illegal;

    fetch_bundle_buffer u_buffer (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .bundle_req_i (bundle_req_i),
        .bundle_i     (bundle_i),
        .lanes_free_i (lanes_free),
        .bundle_ack_o (bundle_ack_o),
        .lane_load_o  (lane_load),
        .lane_instr_o (lane_instr)
    );

    for (genvar g = 0; g < `DECODE_LANES; g++) begin : g_lane
        bmu_decode_lane u_lane (
            .clk_i     (clk_i),
            .reset_i   (reset_i),
            .load_i    (lane_load),
            .instr_i   (lane_instr[g]),
            .op_o      (lane_op[g]),
            .rs1_o     (lane_rs1[g]),
            .rs2_o     (lane_rs2[g]),
            .rd_o      (lane_rd[g]),
            .imm_o     (lane_imm[g]),
            .use_imm_o (lane_use_imm[g]),
            .illegal_o (lane_illegal[g])
        );
    end

    bmu_uop_collector u_collector (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .load_i         (lane_load),
        .lane_op_i      (lane_op),
        .lane_rs1_i     (lane_rs1),
        .lane_rs2_i     (lane_rs2),
        .lane_rd_i      (lane_rd),
        .lane_imm_i     (lane_imm),
        .lane_use_imm_i (lane_use_imm),
        .lane_illegal_i (lane_illegal),
        .uop_ack_i      (uop_ack_i),
        .lanes_free_o   (lanes_free),
        .uop_req_o      (uop_req_o),
        .uop_op_o       (uop_op_o),
        .uop_rs1_o      (uop_rs1_o),
        .uop_rs2_o      (uop_rs2_o),
        .uop_rd_o       (uop_rd_o),
        .uop_imm_o      (uop_imm_o),
        .uop_use_imm_o  (uop_use_imm_o),
        .uop_illegal_o  (uop_illegal_o),
        .uop_lane_o     (uop_lane_o)
    );

endmodule : bmu_decode_top

// ==== design/bmu_uop_collector.sv ====
`include "bmu_consts.svh"

module bmu_uop_collector (
    input  logic                                            clk_i,
    input  logic                                            reset_i,
    input  logic                                            load_i,
    input  bmu_uop_pkg::bmu_op_t [`DECODE_LANES-1:0]        lane_op_i,
    input  riscv_isa_pkg::reg_addr_t [`DECODE_LANES-1:0]    lane_rs1_i,
    input  riscv_isa_pkg::reg_addr_t [`DECODE_LANES-1:0]    lane_rs2_i,
    input  riscv_isa_pkg::reg_addr_t [`DECODE_LANES-1:0]    lane_rd_i,
    input  logic [`DECODE_LANES-1:0][`XLEN-1:0]             lane_imm_i,
    input  logic [`DECODE_LANES-1:0]                        lane_use_imm_i,
    input  logic [`DECODE_LANES-1:0]                        lane_illegal_i,
    input  logic                                            uop_ack_i,
    output logic                                            lanes_free_o,
    output logic                                            uop_req_o,
    output bmu_uop_pkg::bmu_op_t                            uop_op_o,
    output riscv_isa_pkg::reg_addr_t                        uop_rs1_o,
    output riscv_isa_pkg::reg_addr_t                        uop_rs2_o,
    output riscv_isa_pkg::reg_addr_t                        uop_rd_o,
    output logic [`XLEN-1:0]                                uop_imm_o,
    output logic                                            uop_use_imm_o,
    output logic                                            uop_illegal_o,
    output logic [`LANE_IDX_W-1:0]                          uop_lane_o
);

    localparam logic [`LANE_IDX_W-1:0] LAST_LANE = `LANE_IDX_W'(`DECODE_LANES - 1);

    logic                   busy_q;
    logic [`LANE_IDX_W-1:0] lane_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            busy_q    <= 1'b0;
            lane_q    <= '0;
            uop_req_o <= 1'b0;
        end else if (load_i) begin
            busy_q    <= 1'b1;  // Start with lane 0.
            lane_q    <= '0;
            uop_req_o <= 1'b1;
        end else if (busy_q) begin
            if (uop_req_o && uop_ack_i) begin
                uop_req_o <= 1'b0;
            end else if (!uop_req_o && !uop_ack_i) begin
                // Handshake closed, next lane or done.
                if (lane_q == LAST_LANE) begin
                    busy_q <= 1'b0;
                end else begin
                    lane_q    <= lane_q + 1'b1;
                    uop_req_o <= 1'b1;
                end
            end
        end
    end

    assign lanes_free_o  = ~busy_q;
    assign uop_lane_o    = lane_q;
    assign uop_op_o      = lane_op_i[lane_q];  // Lanes hold while we drain.
    assign uop_rs1_o     = lane_rs1_i[lane_q];
    assign uop_rs2_o     = lane_rs2_i[lane_q];
    assign uop_rd_o      = lane_rd_i[lane_q];
    assign uop_imm_o     = lane_imm_i[lane_q];
    assign uop_use_imm_o = lane_use_imm_i[lane_q];
    assign uop_illegal_o = lane_illegal_i[lane_q];

    // Request only withdrawn once the sink has acknowledged.
    a_req_held_until_ack: assert property (@(posedge clk_i) disable iff (reset_i)
        $fell(uop_req_o) |-> $past(uop_ack_i));

endmodule : bmu_uop_collector

// ==== design/bmu_uop_pkg.sv ====
package bmu_uop_pkg;

    // One code per supported operation.
    typedef enum logic [4:0] {
        BMU_NONE = 5'd0,
        BMU_ANDN, BMU_ORN, BMU_XNOR,
        BMU_ROL, BMU_ROR,
        BMU_MIN, BMU_MINU, BMU_MAX, BMU_MAXU,
        BMU_SH1ADD, BMU_SH2ADD, BMU_SH3ADD,
        BMU_BSET, BMU_BCLR, BMU_BINV, BMU_BEXT,
        BMU_BSETI,
        BMU_BCLRI,
        BMU_BINVI,
        BMU_BEXTI,
        BMU_RORI,
        BMU_REV8,
        BMU_ORCB
    } bmu_op_t;

endpackage : bmu_uop_pkg

// ==== design/fetch_bundle_buffer.sv ====
`include "bmu_consts.svh"

module fetch_bundle_buffer (
    input  logic                                       clk_i,
    input  logic                                       reset_i,
    input  logic                                       bundle_req_i,
    input  riscv_isa_pkg::instr_t [`DECODE_LANES-1:0]  bundle_i,
    input  logic                                       lanes_free_i,
    output logic                                       bundle_ack_o,
    output logic                                       lane_load_o,
    output riscv_isa_pkg::instr_t [`DECODE_LANES-1:0]  lane_instr_o
);

    logic full_q;
    logic capture;

    riscv_isa_pkg::instr_t [`DECODE_LANES-1:0] bundle_q;

    assign capture     = bundle_req_i & ~bundle_ack_o & ~full_q;  // New request, slot empty.
    assign lane_load_o = full_q & lanes_free_i;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            full_q       <= 1'b0;
            bundle_ack_o <= 1'b0;
        end else begin
            if (capture) begin
                full_q       <= 1'b1;
                bundle_ack_o <= 1'b1;
            end
            if (lane_load_o) begin
                full_q <= 1'b0;  // Handed to the lanes.
            end
            if (bundle_ack_o && !bundle_req_i) begin
                bundle_ack_o <= 1'b0;  // Return to zero.
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (capture) begin
            bundle_q <= bundle_i;
        end
    end

    assign lane_instr_o = bundle_q;

    // An acknowledge only ever follows a capture into an empty slot.
    a_no_capture_when_full: assert property (@(posedge clk_i) disable iff (reset_i)
        $rose(bundle_ack_o) |-> $past(!full_q) && full_q);

endmodule : fetch_bundle_buffer

// ==== design/riscv_isa_pkg.sv ====
`include "bmu_consts.svh"

package riscv_isa_pkg;

    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;

    // **************************************************
    // Instruction word, seen as R type or I type
    // **************************************************

    typedef union packed {
        struct packed {
            funct7_t   funct7;
            reg_addr_t rs2;    // Also the shift amount of the immediate forms.
            reg_addr_t rs1;
            funct3_t   funct3;
            reg_addr_t rd;
            opcode_t   opcode;
        } r;

        struct packed {
            logic [11:0] imm12;
            reg_addr_t   rs1;
            funct3_t     funct3;
            reg_addr_t   rd;
            opcode_t     opcode;
        } i;
    } instr_t;

endpackage : riscv_isa_pkg

// ==== flist.f ====
+incdir+design
+incdir+testbench
design/riscv_isa_pkg.sv
design/bmu_uop_pkg.sv
design/fetch_bundle_buffer.sv
design/bmu_decode_lane.sv
design/bmu_uop_collector.sv
design/bmu_decode_top.sv
testbench/tb_bmu_decode.sv

// ==== testbench/bmu_ref_model.svh ====
`ifndef BMU_REF_MODEL_SVH
`define BMU_REF_MODEL_SVH

localparam int NUM_ENC     = 23;
localparam int FIRST_SHAMT = 16;  // Rows 16 to 20 carry a shift amount.
localparam int FIRST_BYTE  = 21;  // Rows 21 and 22 match the whole imm12.
localparam int EXP_W       = 5 + 3 * `REG_ADDR_W + `XLEN + 2;

// **************************************************
// Encoding table
// **************************************************

// Key is {word[31:20], word[14:12]}, funct7 and rs2 above funct3.
localparam logic [14:0] ENC_KEY [NUM_ENC] = '{
    {7'b0100000, 5'd0, 3'b111}, {7'b0100000, 5'd0, 3'b110}, {7'b0100000, 5'd0, 3'b100},
    {7'b0110000, 5'd0, 3'b001}, {7'b0110000, 5'd0, 3'b101},
    {7'b0000101, 5'd0, 3'b100}, {7'b0000101, 5'd0, 3'b101},
    {7'b0000101, 5'd0, 3'b110}, {7'b0000101, 5'd0, 3'b111},
    {7'b0010000, 5'd0, 3'b010}, {7'b0010000, 5'd0, 3'b100}, {7'b0010000, 5'd0, 3'b110},
    {7'b0010100, 5'd0, 3'b001}, {7'b0100100, 5'd0, 3'b001},
    {7'b0110100, 5'd0, 3'b001}, {7'b0100100, 5'd0, 3'b101},
    {7'b0010100, 5'd0, 3'b001}, {7'b0100100, 5'd0, 3'b001},
    {7'b0110100, 5'd0, 3'b001}, {7'b0100100, 5'd0, 3'b101}, {7'b0110000, 5'd0, 3'b101},
    {12'b011010011000, 3'b101}, {12'b001010000111, 3'b101}
};

localparam bmu_uop_pkg::bmu_op_t ENC_OP [NUM_ENC] = '{
    bmu_uop_pkg::BMU_ANDN, bmu_uop_pkg::BMU_ORN, bmu_uop_pkg::BMU_XNOR,
    bmu_uop_pkg::BMU_ROL, bmu_uop_pkg::BMU_ROR,
    bmu_uop_pkg::BMU_MIN, bmu_uop_pkg::BMU_MINU, bmu_uop_pkg::BMU_MAX, bmu_uop_pkg::BMU_MAXU,
    bmu_uop_pkg::BMU_SH1ADD, bmu_uop_pkg::BMU_SH2ADD, bmu_uop_pkg::BMU_SH3ADD,
    bmu_uop_pkg::BMU_BSET, bmu_uop_pkg::BMU_BCLR, bmu_uop_pkg::BMU_BINV, bmu_uop_pkg::BMU_BEXT,
    bmu_uop_pkg::BMU_BSETI, bmu_uop_pkg::BMU_BCLRI, bmu_uop_pkg::BMU_BINVI,
    bmu_uop_pkg::BMU_BEXTI, bmu_uop_pkg::BMU_RORI,
    bmu_uop_pkg::BMU_REV8, bmu_uop_pkg::BMU_ORCB
};

// Row k with the free fields taken from rnd, bits 1:0 left as in rnd.
function automatic logic [31:0] enc_instr(input int k, input logic [31:0] rnd);
    logic [31:0] word;
    logic [6:0]  opc;
    word        = rnd;
    opc         = (k < FIRST_SHAMT) ? `OPC_OP : `OPC_OP_IMM;
    word[31:25] = ENC_KEY[k][14:8];
    word[14:12] = ENC_KEY[k][2:0];
    word[6:2]   = opc[6:2];
    if (k >= FIRST_BYTE) begin
        word[24:20] = ENC_KEY[k][7:3];
    end
    return word;
endfunction

// **************************************************
// Reference decode
// **************************************************

function automatic logic [EXP_W-1:0] bmu_ref_decode(input logic [31:0] word);
    logic [14:0]              key;
    logic [14:0]              care;
    logic [6:0]               opc;
    int                       hit;
    bmu_uop_pkg::bmu_op_t     op;
    riscv_isa_pkg::reg_addr_t rs1;
    riscv_isa_pkg::reg_addr_t rs2;
    riscv_isa_pkg::reg_addr_t rd;
    logic [`XLEN-1:0]         imm;
    logic                     use_imm;
    key = {word[31:20], word[14:12]};
    hit = -1;
    for (int k = 0; k < NUM_ENC; k++) begin
        care = (k < FIRST_BYTE) ? 15'h7F07 : 15'h7FFF;  // Rs2 bits only count for byte rows.
        opc  = (k < FIRST_SHAMT) ? `OPC_OP : `OPC_OP_IMM;
        if ((key & care) == ENC_KEY[k] && word[6:2] == opc[6:2]) begin
            hit = k;
        end
    end
    use_imm = (hit >= FIRST_SHAMT) && (hit < FIRST_BYTE);
    op      = (hit >= 0) ? ENC_OP[hit] : bmu_uop_pkg::BMU_NONE;
    rs1     = (hit >= 0) ? word[19:15] : '0;
    rd      = (hit >= 0) ? word[11:7] : '0;
    rs2     = (hit >= 0 && hit < FIRST_SHAMT) ? word[24:20] : '0;
    imm     = use_imm ? {{(`XLEN - `REG_ADDR_W){1'b0}}, word[24:20]} : '0;
    return {op, rs1, rs2, rd, imm, use_imm, word[1:0] != 2'b11};
endfunction

`endif

// ==== testbench/tb_bmu_decode.sv ====
`include "bmu_consts.svh"

module tb_bmu_decode;

    `include "bmu_ref_model.svh"

    localparam int NUM_RANDOM   = 30;  // Random words with bits 1:0 = 11.
    localparam int NUM_WILD     = 16;  // Fully random words.
    localparam int NUM_WORDS    = 2 * NUM_ENC + NUM_RANDOM + NUM_WILD;
    localparam int CYCLE_LIMIT  = 40 * NUM_WORDS;
    localparam int QUIET_CYCLES = 16;  // Idle issue side once all bundles are in.

    logic                                      clk_i;
    logic                                      reset_i;
    logic                                      bundle_req_i;
    riscv_isa_pkg::instr_t [`DECODE_LANES-1:0] bundle_i;
    logic                                      bundle_ack_o;
    logic                                      uop_req_o;
    logic                                      uop_ack_i;
    bmu_uop_pkg::bmu_op_t                      uop_op_o;
    riscv_isa_pkg::reg_addr_t                  uop_rs1_o;
    riscv_isa_pkg::reg_addr_t                  uop_rs2_o;
    riscv_isa_pkg::reg_addr_t                  uop_rd_o;
    logic [`XLEN-1:0]                          uop_imm_o;
    logic                                      uop_use_imm_o;
    logic                                      uop_illegal_o;
    logic [`LANE_IDX_W-1:0]                    uop_lane_o;

    logic             source_done;
    logic [EXP_W-1:0] exp_q [$];

    bmu_decode_top DUT (.*);

    task automatic step_cycle();
        @(posedge clk_i);
        #1;
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            abort_run($sformatf("Error at time %0t: %s is %h, expected %h",
                                $time, what, got, expected));
        end
    endtask

    // Table rows first, legal then with bad low bits, then random words.
    function automatic logic [31:0] make_word(input int idx);
        logic [31:0] word;
        word = $urandom;
        if (idx < 2 * NUM_ENC) begin
            word      = enc_instr(idx % NUM_ENC, word);
            word[1:0] = (idx < NUM_ENC) ? 2'b11 : 2'(idx % 3);
        end else if (idx < 2 * NUM_ENC + NUM_RANDOM) begin
            word[1:0] = 2'b11;
            case (idx % 4)
                0: word[6:0] = `OPC_OP;
                1: word[6:0] = `OPC_OP_IMM;
                default: ;
            endcase
        end
        return word;
    endfunction

    initial begin : clock_gen
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // **************************************************
    // Source, sink and scoreboard
    // **************************************************

    initial begin : source
        logic [31:0] word;
        void'($urandom(32'h3b32_c308));
        source_done  = 1'b0;
        reset_i      = 1'b1;
        bundle_req_i = 1'b0;
        bundle_i     = '0;
        repeat (2) @(posedge clk_i);
        #1;
        reset_i = 1'b0;
        for (int b = 0; b < NUM_WORDS / `DECODE_LANES; b++) begin
            for (int l = 0; l < `DECODE_LANES; l++) begin
                word        = make_word(b * `DECODE_LANES + l);
                bundle_i[l] = word;
                exp_q.push_back(bmu_ref_decode(word));
            end
            bundle_req_i = 1'b1;
            while (!bundle_ack_o) step_cycle();  // Stalls while the buffer is full.
            bundle_req_i = 1'b0;
            while (bundle_ack_o) step_cycle();
        end
        source_done = 1'b1;
    end

    initial begin : sink
        int delay;
        uop_ack_i = 1'b0;
        forever begin
            step_cycle();
            if (uop_req_o) begin
                delay = int'($urandom_range(5, 0));
                repeat (delay) step_cycle();
                uop_ack_i = 1'b1;
                while (uop_req_o) step_cycle();
                uop_ack_i = 1'b0;
            end
        end
    end

    initial begin : scoreboard
        int                       seen;
        int                       cycles;
        int                       quiet;
        logic                     req_prev;
        logic [4:0]               e_op;
        riscv_isa_pkg::reg_addr_t e_rs1;
        riscv_isa_pkg::reg_addr_t e_rs2;
        riscv_isa_pkg::reg_addr_t e_rd;
        logic [`XLEN-1:0]         e_imm;
        logic                     e_use_imm;
        logic                     e_illegal;
        seen     = 0;
        cycles   = 0;
        quiet    = 0;
        req_prev = 1'b0;
        while (!(source_done && quiet >= QUIET_CYCLES)) begin
            step_cycle();
            cycles++;
            if (cycles > CYCLE_LIMIT) begin
                abort_run($sformatf("Timeout: %0d of %0d micro-ops seen after %0d cycles.",
                                    seen, NUM_WORDS, cycles));
            end
            quiet = uop_req_o ? 0 : quiet + 1;
            if (uop_req_o && !req_prev) begin
                if (exp_q.size() == 0) begin
                    abort_run("A micro-op came out with no instruction left to match it.");
                end
                {e_op, e_rs1, e_rs2, e_rd, e_imm, e_use_imm, e_illegal} = exp_q.pop_front();
                check_value("uop_op_o", 32'(uop_op_o), 32'(e_op));
                check_value("uop_rs1_o", 32'(uop_rs1_o), 32'(e_rs1));
                check_value("uop_rs2_o", 32'(uop_rs2_o), 32'(e_rs2));
                check_value("uop_rd_o", 32'(uop_rd_o), 32'(e_rd));
                check_value("uop_imm_o", 32'(uop_imm_o), 32'(e_imm));
                check_value("uop_use_imm_o", 32'(uop_use_imm_o), 32'(e_use_imm));
                check_value("uop_illegal_o", 32'(uop_illegal_o), 32'(e_illegal));
                check_value("uop_lane_o", 32'(uop_lane_o), 32'(seen % `DECODE_LANES));
                seen++;
            end
            req_prev = uop_req_o;
        end
        if (exp_q.size() != 0) begin
            abort_run($sformatf("%0d expected micro-ops were never issued.", exp_q.size()));
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule : tb_bmu_decode
